//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f sources.f \
    --top-module pipelineControlTb \
    -o simv

./obj_dir/simv

//--- sources.f
+incdir+verilog
verilog/pipelinePkg.sv
verilog/csrPkg.sv
verilog/hazardIf.sv
verilog/hazardDetection.sv
verilog/forwardingUnit.sv
verilog/pipelineRegs.sv
verilog/hazardCsr.sv
verilog/pipelineControl.sv
tb/clockGen.sv
tb/pipelineControlTb.sv

//--- tb/clockGen.sv
`default_nettype none

// Free-running clock plus synchronous reset held for a few edges
module clockGen #(
    parameter int Period      = 100,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #10 reset = 1'b0; // Released just after the last reset edge
    end

endmodule

`default_nettype wire

//--- tb/pipelineControlTb.sv
`default_nettype none

`include "pipeline_config.svh"

module pipelineControlTb;

    localparam int DriveDelay = 10;  // After rising edge
    localparam int MaxCycles  = 400; // Per table run

    typedef struct {
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   usesRt;
        logic                   regWrite;
        logic                   memRead;
        logic                   isBranch;
        logic                   isJump;
        logic                   isJR;
        logic                   taken;   // exBranchTaken while this row is in ID
        int                     stalls;  // Expected stall cycles in ID
        logic                   ifF;     // Expected flushes once it leaves stall
        logic                   idF;
        logic [1:0]             fa;      // Expected selects in EX
        logic [1:0]             fb;
    } rowT;

    logic clk, reset;
    logic fetchValid, fetchUsesRt, fetchRegWrite, fetchMemRead;
    logic fetchIsBranch, fetchIsJump, fetchIsJR, exBranchTaken, csrWrite;
    logic [`REG_ADDR_W-1:0] fetchRs, fetchRt, fetchRd, wbRd;
    logic [1:0]             csrAddrIn, forwardA, forwardB;
    logic [`COUNT_W-1:0]    csrWdata, csrRdata;
    logic pcWrite, ifFlush, idFlush, wbRegWrite;

    rowT rows[$];
    int  seed = 46420;
    int  stallTotal = 0; // Expected stall cycles since reset
    int  flushTotal = 0; // Expected IF flush cycles since reset

    clockGen #(.Period(100), .ResetCycles(5)) clock0 (.clk(clk), .reset(reset));

    pipelineControl dut0 (
        .clk(clk), .reset(reset),
        .fetchValid(fetchValid), .fetchRs(fetchRs), .fetchRt(fetchRt), .fetchRd(fetchRd),
        .fetchUsesRt(fetchUsesRt), .fetchRegWrite(fetchRegWrite),
        .fetchMemRead(fetchMemRead), .fetchIsBranch(fetchIsBranch),
        .fetchIsJump(fetchIsJump), .fetchIsJR(fetchIsJR), .exBranchTaken(exBranchTaken),
        .csrWrite(csrWrite), .csrAddrIn(csrAddrIn), .csrWdata(csrWdata),
        .csrRdata(csrRdata), .pcWrite(pcWrite), .ifFlush(ifFlush), .idFlush(idFlush),
        .forwardA(forwardA), .forwardB(forwardB), .wbRegWrite(wbRegWrite), .wbRd(wbRd)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic addOp(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
                         input logic usesRt, input logic regWrite, input logic memRead,
                         input int stalls, input logic [1:0] fa, input logic [1:0] fb);
        rowT r;
        r = '{rs: rs, rt: rt, rd: rd, usesRt: usesRt, regWrite: regWrite,
              memRead: memRead, isBranch: 1'b0, isJump: 1'b0, isJR: 1'b0, taken: 1'b0,
              stalls: stalls, ifF: 1'b0, idF: 1'b0, fa: fa, fb: fb};
        rows.push_back(r);
    endtask

    // Patch control bits and flush expectations onto the last row
    task automatic setFlow(input logic isBranch, input logic isJump, input logic isJR,
                           input logic taken, input logic ifF, input logic idF);
        int last;
        last = rows.size() - 1;
        rows[last].isBranch = isBranch;
        rows[last].isJump   = isJump;
        rows[last].isJR     = isJR;
        rows[last].taken    = taken;
        rows[last].ifF      = ifF;
        rows[last].idF      = idF;
    endtask

    task automatic driveIdle();
        fetchValid    = 1'b0;
        fetchRs       = '0;
        fetchRt       = '0;
        fetchRd       = '0;
        fetchUsesRt   = 1'b0;
        fetchRegWrite = 1'b0;
        fetchMemRead  = 1'b0;
        fetchIsBranch = 1'b0;
        fetchIsJump   = 1'b0;
        fetchIsJR     = 1'b0;
        exBranchTaken = 1'b0;
        csrWrite      = 1'b0;
    endtask

    task automatic writeCsr(input logic [1:0] addr, input logic [`COUNT_W-1:0] data);
        @(posedge clk);
        #DriveDelay;
        csrWrite  = 1'b1;
        csrAddrIn = addr;
        csrWdata  = data;
        @(posedge clk);
        #DriveDelay;
        csrWrite = 1'b0;
    endtask

    task automatic readCsr(input string name, input logic [1:0] addr,
                           input logic [31:0] expected);
        @(posedge clk);
        #DriveDelay;
        csrAddrIn = addr;
        @(negedge clk); // Combinational read settled
        checkValue(name, 32'(csrRdata), expected);
    endtask

    // ------------------------------
    // Table runner with slot model
    // ------------------------------
    task automatic runRows();
        int  fetchIdx, idSlot, exSlot, memSlot, wbSlot, idStalls, cycle;
        logic expPc, expIf, expId, expWb;
        bit  done;
        fetchIdx = 0;
        idSlot   = -1;
        exSlot   = -1;
        memSlot  = -1;
        wbSlot   = -1;
        idStalls = 0;
        done     = 0;
        for (cycle = 0; cycle < MaxCycles && !done; cycle++) begin
            @(posedge clk);
            #DriveDelay;
            driveIdle();
            if (fetchIdx < rows.size()) begin // Held while stalled
                fetchValid    = 1'b1;
                fetchRs       = rows[fetchIdx].rs;
                fetchRt       = rows[fetchIdx].rt;
                fetchRd       = rows[fetchIdx].rd;
                fetchUsesRt   = rows[fetchIdx].usesRt;
                fetchRegWrite = rows[fetchIdx].regWrite;
                fetchMemRead  = rows[fetchIdx].memRead;
                fetchIsBranch = rows[fetchIdx].isBranch;
                fetchIsJump   = rows[fetchIdx].isJump;
                fetchIsJR     = rows[fetchIdx].isJR;
            end
            if (idSlot >= 0) exBranchTaken = rows[idSlot].taken;
            @(negedge clk);

            expPc = 1'b1; // Defaults for an empty ID slot
            expIf = 1'b0;
            expId = 1'b0;
            if (idSlot >= 0) begin
                expPc = (idStalls >= rows[idSlot].stalls);
                expIf = expPc && rows[idSlot].ifF;
                expId = expPc && rows[idSlot].idF;
            end
            checkValue("pcWrite", 32'(pcWrite), 32'(expPc));
            checkValue("ifFlush", 32'(ifFlush), 32'(expIf));
            checkValue("idFlush", 32'(idFlush), 32'(expId));
            if (exSlot >= 0) begin
                checkValue("forwardA", 32'(forwardA), 32'(rows[exSlot].fa));
                checkValue("forwardB", 32'(forwardB), 32'(rows[exSlot].fb));
            end else begin
                checkValue("forwardA", 32'(forwardA), 32'(pipelinePkg::fwdNone));
                checkValue("forwardB", 32'(forwardB), 32'(pipelinePkg::fwdNone));
            end
            expWb = (wbSlot >= 0) && rows[wbSlot].regWrite; // Killed rows never get here
            checkValue("wbRegWrite", 32'(wbRegWrite), 32'(expWb));
            if (expWb) checkValue("wbRd", 32'(wbRd), 32'(rows[wbSlot].rd));
            stallTotal += expPc ? 0 : 1;
            flushTotal += expIf ? 1 : 0;

            // Advance slots to match the coming edge
            wbSlot  = memSlot;
            memSlot = exSlot;
            exSlot  = (expId || !expPc) ? -1 : idSlot;
            if (!expPc) begin
                idStalls++;
            end else begin
                idSlot   = (expIf || fetchIdx >= rows.size()) ? -1 : fetchIdx;
                idStalls = 0;
                if (fetchIdx < rows.size()) fetchIdx++;
            end
            done = (fetchIdx >= rows.size()) && idSlot < 0 && exSlot < 0 &&
                   memSlot < 0 && wbSlot < 0;
        end
        if (!done) begin
            $display("Timeout: table run did not drain within %0d cycles", MaxCycles);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
        rows.delete();
    endtask

    // ------------------------------
    // Tables
    // ------------------------------
    task automatic buildForwardRows();
        logic [4:0] a, b, d;
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);     // NOP
        addOp(2, 3, 1, 1, 1, 0, 0, 0, 0);     // r1 = r2 + r3
        addOp(1, 5, 4, 1, 1, 0, 0, 2, 0);     // Distance one, fwdMem
        addOp(7, 1, 6, 1, 1, 0, 0, 0, 1);     // Distance two, fwdWb
        addOp(4, 6, 2, 1, 1, 0, 0, 1, 2);
        addOp(1, 1, 2, 1, 1, 0, 0, 0, 0);     // r2 again
        addOp(2, 3, 7, 1, 1, 0, 0, 2, 0);     // Both write r2, EX/MEM wins
        addOp(1, 1, 0, 1, 1, 0, 0, 0, 0);     // Writes r0
        addOp(0, 0, 5, 1, 1, 0, 0, 0, 0);     // r0 never forwards
        addOp(1, 3, 3, 0, 1, 1, 0, 0, 0);     // lw r3
        addOp(6, 3, 4, 0, 1, 0, 0, 0, 2);     // rt unused, no stall
        addOp(4, 5, 5, 0, 1, 1, 0, 2, 0);     // lw r5
        addOp(5, 1, 6, 1, 1, 0, 1, 1, 0);     // Load-use, one stall then fwdWb
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);     // Jump
        setFlow(0, 1, 0, 0, 1, 0);
        addOp(1, 1, 1, 1, 1, 0, 0, 0, 0);     // Wrong path, dropped
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);     // JR
        setFlow(0, 0, 1, 0, 1, 0);
        addOp(3, 3, 3, 1, 1, 0, 0, 0, 0);     // Wrong path, dropped
        addOp(1, 2, 0, 1, 0, 0, 0, 0, 0);     // Branch
        setFlow(1, 0, 0, 0, 0, 0);
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);     // Jump with taken branch in EX
        setFlow(0, 1, 0, 1, 1, 1);
        addOp(2, 2, 2, 1, 1, 0, 0, 0, 0);     // Dropped
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        addOp(1, 3, 3, 0, 1, 1, 0, 0, 0);     // lw r3
        addOp(3, 3, 4, 1, 1, 0, 0, 0, 0);     // Load-use lost to taken branch
        setFlow(0, 0, 0, 1, 1, 1);
        addOp(5, 5, 5, 1, 1, 0, 0, 0, 0);     // Dropped
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        // Random fillers, no writes so nothing forwards
        for (int i = 0; i < 4; i++) begin
            a = 5'($unsigned($random(seed)) % 7 + 1);
            b = 5'($unsigned($random(seed)) % 7 + 1);
            d = 5'($unsigned($random(seed)) % 7 + 1);
            addOp(a, b, d, 1, 0, 0, 0, 0, 0);
        end
    endtask

    // Forwarding off, every select stays fwdNone
    task automatic buildNoForwardRows();
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
        addOp(2, 3, 1, 1, 1, 0, 0, 0, 0);     // r1 = r2 + r3
        addOp(1, 5, 4, 1, 1, 0, 2, 0, 0);     // Distance one, two stalls
        addOp(7, 7, 6, 1, 1, 0, 0, 0, 0);
        addOp(4, 1, 2, 1, 1, 0, 1, 0, 0);     // Distance two, one stall
        addOp(3, 2, 5, 0, 1, 0, 0, 0, 0);     // rt unused, r2 in EX/MEM not bypassed
        addOp(0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------
    initial begin
        int waitCount;
        driveIdle();
        csrAddrIn = 2'd0;
        csrWdata  = '0;

        waitCount = 0;
        while (reset !== 1'b0 && waitCount < 50) begin
            @(posedge clk);
            waitCount++;
        end
        if (reset !== 1'b0) begin
            $display("Timeout: reset never released");
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end

        // Reset state
        @(negedge clk);
        checkValue("pcWrite", 32'(pcWrite), 32'h1);
        checkValue("ifFlush", 32'(ifFlush), 32'h0);
        checkValue("idFlush", 32'(idFlush), 32'h0);
        checkValue("forwardA", 32'(forwardA), 32'(pipelinePkg::fwdNone));
        checkValue("forwardB", 32'(forwardB), 32'(pipelinePkg::fwdNone));
        readCsr("csrRdata", 2'(csrPkg::csrCtrl), 32'h1);
        readCsr("csrRdata", 2'(csrPkg::csrStallCount), 32'h0);
        readCsr("csrRdata", 2'(csrPkg::csrFlushCount), 32'h0);

        buildForwardRows();
        runRows();

        writeCsr(2'(csrPkg::csrCtrl), '0); // Bypass off
        readCsr("csrRdata", 2'(csrPkg::csrCtrl), 32'h0);
        buildNoForwardRows();
        runRows();

        // Counters against testbench totals, then clear
        readCsr("csrRdata", 2'(csrPkg::csrStallCount), 32'(stallTotal));
        readCsr("csrRdata", 2'(csrPkg::csrFlushCount), 32'(flushTotal));
        writeCsr(2'(csrPkg::csrStallCount), '1);
        writeCsr(2'(csrPkg::csrFlushCount), '1);
        readCsr("csrRdata", 2'(csrPkg::csrStallCount), 32'h0);
        readCsr("csrRdata", 2'(csrPkg::csrFlushCount), 32'h0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/csrPkg.sv
`default_nettype none

// Register map of the hazard configuration block
package csrPkg;

    // ------------------------------
    // Addresses
    // ------------------------------
    typedef enum logic [1:0] {
        csrCtrl       = 2'd0, // Bit 0 forwardEnable
        csrStallCount = 2'd1, // Stall cycles, write clears
        csrFlushCount = 2'd2  // IF flush cycles, write clears
    } csrAddr;

    // Address 3 is unmapped and reads zero

endpackage

`default_nettype wire

//--- verilog/forwardingUnit.sv
`default_nettype none

`include "pipeline_config.svh"

module forwardingUnit (
    input  pipelinePkg::instrTag   idEx,          // Consumer in EX
    input  pipelinePkg::instrTag   exMem,
    input  pipelinePkg::instrTag   memWb,
    input  logic                   forwardEnable,
    output pipelinePkg::forwardSel forwardA,      // rs operand
    output pipelinePkg::forwardSel forwardB       // rt operand
);

    // Source for one operand, EX/MEM outranks MEM/WB
    function automatic pipelinePkg::forwardSel pickSource(
        input logic [`REG_ADDR_W-1:0] src,
        input pipelinePkg::instrTag   mem,
        input pipelinePkg::instrTag   wb
    );
        pickSource = pipelinePkg::fwdNone;
        if (mem.valid && mem.regWrite && (mem.rd != '0) && (mem.rd == src)) begin
            pickSource = pipelinePkg::fwdMem;
        end else if (wb.valid && wb.regWrite && (wb.rd != '0) && (wb.rd == src)) begin
            pickSource = pipelinePkg::fwdWb; // Older result
        end
    endfunction

    // ------------------------------
    // Operand selects
    // ------------------------------
    always_comb begin
        forwardA = pipelinePkg::fwdNone;
        forwardB = pipelinePkg::fwdNone;

        // Bubbles and disabled bypass read the register file
        if (forwardEnable && idEx.valid) begin
            forwardA = pickSource(idEx.rs, exMem, memWb);
            forwardB = pickSource(idEx.rt, exMem, memWb);
        end
    end

endmodule

`default_nettype wire

//--- verilog/hazardCsr.sv
`default_nettype none

`include "pipeline_config.svh"

module hazardCsr (
    input  logic                clk,
    input  logic                reset,
    hazardIf.monitor            hz,
    input  logic                csrWrite,      // Single-cycle write strobe
    input  csrPkg::csrAddr      csrAddrIn,
    input  logic [`COUNT_W-1:0] csrWdata,
    output logic [`COUNT_W-1:0] csrRdata,      // Combinational read
    output logic                forwardEnable
);

    logic [`COUNT_W-1:0] counts [2]; // 0 stall cycles, 1 flush cycles
    logic [1:0]          countEvent;
    logic [1:0]          countClear;

    assign countEvent = {hz.ifFlush, !hz.pcWrite};
    assign countClear = {csrWrite && (csrAddrIn == csrPkg::csrFlushCount),
                         csrWrite && (csrAddrIn == csrPkg::csrStallCount)};

    // ------------------------------
    // Control register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            forwardEnable <= 1'b1; // Bypass on out of reset
        end else if (csrWrite && (csrAddrIn == csrPkg::csrCtrl)) begin
            forwardEnable <= csrWdata[0];
        end
    end

    // ------------------------------
    // Statistics
    // ------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (reset || countClear[i]) begin
                counts[i] <= '0;                    // Clear wins over event
            end else if (countEvent[i] && (counts[i] != '1)) begin
                counts[i] <= counts[i] + 1'b1;      // Sticks at all ones
            end
        end
    end

    always_comb begin
        case (csrAddrIn)
            csrPkg::csrCtrl:       csrRdata = {{(`COUNT_W-1){1'b0}}, forwardEnable};
            csrPkg::csrStallCount: csrRdata = counts[0];
            csrPkg::csrFlushCount: csrRdata = counts[1];
            default:               csrRdata = '0; // Unmapped
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/hazardDetection.sv
`default_nettype none

`include "pipeline_config.svh"

module hazardDetection (
    hazardIf.unit                hz,
    input  pipelinePkg::instrTag ifId,
    input  pipelinePkg::instrTag idEx,
    input  pipelinePkg::instrTag exMem,
    input  logic                 exBranchTaken, // Branch in ID/EX resolved taken
    input  logic                 forwardEnable  // 0 stalls on every RAW
);

    logic loadUse;    // LW in EX feeding ID
    logic rawIdEx;    // Any producer in EX
    logic rawExMem;   // Any producer in MEM
    logic dataHazard;
    logic jumpInId;

    // True when the ID instruction reads dst, r0 never counts
    function automatic logic readsReg(
        input logic [`REG_ADDR_W-1:0] dst,
        input pipelinePkg::instrTag   consumer
    );
        readsReg = (dst != '0) &&
                   ((dst == consumer.rs) ||
                    (consumer.usesRt && (dst == consumer.rt))); // rt only when read
    endfunction

    // ------------------------------
    // Hazard terms
    // ------------------------------
    assign loadUse  = idEx.valid && idEx.memRead && readsReg(idEx.rt, ifId);
    assign rawIdEx  = idEx.valid && idEx.regWrite && readsReg(idEx.rd, ifId);
    assign rawExMem = exMem.valid && exMem.regWrite && readsReg(exMem.rd, ifId);

    // MEM/WB skipped, register file writes first half of cycle
    assign dataHazard = ifId.valid &&
                        (loadUse || (!forwardEnable && (rawIdEx || rawExMem)));

    assign jumpInId = ifId.valid && (ifId.isJump || ifId.isJR);

    // ------------------------------
    // Priority select
    // ------------------------------
    always_comb begin
        hz.pcWrite       = 1'b1; // Normal flow
        hz.ifIdWrite     = 1'b1;
        hz.controlMuxSel = 1'b1;
        hz.ifFlush       = 1'b0;
        hz.idFlush       = 1'b0;

        if (exBranchTaken) begin
            // Wrong-path instructions in IF and ID both die
            hz.ifFlush = 1'b1;
            hz.idFlush = 1'b1;
        end else if (jumpInId) begin
            hz.ifFlush = 1'b1; // Target known in ID, one slot lost
        end else if (dataHazard) begin
            hz.pcWrite       = 1'b0; // Hold fetch
            hz.ifIdWrite     = 1'b0; // Hold consumer in ID
            hz.controlMuxSel = 1'b0; // Bubble into EX
        end
    end

endmodule

`default_nettype wire

//--- verilog/hazardIf.sv
`default_nettype none

// Stall and flush controls from the hazard unit
interface hazardIf;

    logic pcWrite;       // 0 freezes PC, fetch re-presents tag
    logic ifIdWrite;     // 0 freezes IF/ID
    logic controlMuxSel; // 0 inserts bubble into ID/EX
    logic ifFlush;       // Kill instruction entering IF/ID
    logic idFlush;       // Kill instruction entering ID/EX

    // Producer
    modport unit (output pcWrite, ifIdWrite, controlMuxSel, ifFlush, idFlush);

    // Pipeline registers
    modport pipe (input pcWrite, ifIdWrite, controlMuxSel, ifFlush, idFlush);

    // Statistics only look at stall and flush
    modport monitor (input pcWrite, ifFlush);

endinterface

`default_nettype wire

//--- verilog/pipelineControl.sv
`default_nettype none

`include "pipeline_config.svh"

module pipelineControl (
    input  logic                   clk,
    input  logic                   reset,
    // Fetch side, held while pcWrite is low
    input  logic                   fetchValid,
    input  logic [`REG_ADDR_W-1:0] fetchRs,
    input  logic [`REG_ADDR_W-1:0] fetchRt,
    input  logic [`REG_ADDR_W-1:0] fetchRd,
    input  logic                   fetchUsesRt,
    input  logic                   fetchRegWrite,
    input  logic                   fetchMemRead,
    input  logic                   fetchIsBranch,
    input  logic                   fetchIsJump,
    input  logic                   fetchIsJR,
    input  logic                   exBranchTaken,
    // Configuration port
    input  logic                   csrWrite,
    input  logic [1:0]             csrAddrIn,
    input  logic [`COUNT_W-1:0]    csrWdata,
    output logic [`COUNT_W-1:0]    csrRdata,
    // Controls and retire
    output logic                   pcWrite,
    output logic                   ifFlush,
    output logic                   idFlush,
    output logic [1:0]             forwardA,
    output logic [1:0]             forwardB,
    output logic                   wbRegWrite,
    output logic [`REG_ADDR_W-1:0] wbRd
);

    pipelinePkg::instrTag fetchTag;
    pipelinePkg::instrTag ifId;
    pipelinePkg::instrTag idEx;
    pipelinePkg::instrTag exMem;
    pipelinePkg::instrTag memWb;
    logic                 forwardEnable;

    hazardIf hzBus ();

    assign fetchTag = '{valid: fetchValid, rs: fetchRs, rt: fetchRt, rd: fetchRd,
                        usesRt: fetchUsesRt, regWrite: fetchRegWrite,
                        memRead: fetchMemRead, isBranch: fetchIsBranch,
                        isJump: fetchIsJump, isJR: fetchIsJR};

    // ------------------------------
    // Blocks
    // ------------------------------
    hazardDetection hazard0 (.hz(hzBus), .ifId(ifId), .idEx(idEx), .exMem(exMem),
                             .exBranchTaken(exBranchTaken),
                             .forwardEnable(forwardEnable));

    forwardingUnit forward0 (.idEx(idEx), .exMem(exMem), .memWb(memWb),
                             .forwardEnable(forwardEnable),
                             .forwardA(forwardA), .forwardB(forwardB));

    pipelineRegs regs0 (.clk(clk), .reset(reset), .fetchTag(fetchTag), .hz(hzBus),
                        .ifId(ifId), .idEx(idEx), .exMem(exMem), .memWb(memWb));

    hazardCsr csr0 (.clk(clk), .reset(reset), .hz(hzBus), .csrWrite(csrWrite),
                    .csrAddrIn(csrPkg::csrAddr'(csrAddrIn)), .csrWdata(csrWdata),
                    .csrRdata(csrRdata), .forwardEnable(forwardEnable));

    // Control outputs straight off the bus
    assign pcWrite = hzBus.pcWrite;
    assign ifFlush = hzBus.ifFlush;
    assign idFlush = hzBus.idFlush;

    // Retiring write, flushed slots are invalid
    assign wbRegWrite = memWb.valid && memWb.regWrite;
    assign wbRd       = memWb.rd;

endmodule

`default_nettype wire

//--- verilog/pipelinePkg.sv
`default_nettype none

`include "pipeline_config.svh"

// Types shared by the pipeline tag registers and the hazard logic
package pipelinePkg;

    // EX operand source, textbook MIPS encoding
    typedef enum logic [1:0] {
        fwdNone = 2'b00, // Register file value
        fwdWb   = 2'b01, // MEM/WB result
        fwdMem  = 2'b10  // EX/MEM result, newest wins
    } forwardSel;

    // One instruction as seen by hazard control, no data or PC
    typedef struct packed {
        logic                   valid;    // 0 for bubble or flushed slot
        logic [`REG_ADDR_W-1:0] rs;       // First source
        logic [`REG_ADDR_W-1:0] rt;       // Second source, load destination
        logic [`REG_ADDR_W-1:0] rd;       // Write-back destination
        logic                   usesRt;   // rt is really read
        logic                   regWrite; // Writes rd at WB
        logic                   memRead;  // LW
        logic                   isBranch; // BEQ/BNE
        logic                   isJump;   // J/JAL
        logic                   isJR;     // JR
    } instrTag;

endpackage

`default_nettype wire

//--- verilog/pipelineRegs.sv
`default_nettype none

module pipelineRegs (
    input  logic                 clk,
    input  logic                 reset,
    input  pipelinePkg::instrTag fetchTag, // Decoded instruction from fetch
    hazardIf.pipe                hz,
    output pipelinePkg::instrTag ifId,
    output pipelinePkg::instrTag idEx,
    output pipelinePkg::instrTag exMem,
    output pipelinePkg::instrTag memWb
);

    // Empty slot, valid low and all fields zero
    localparam pipelinePkg::instrTag EmptyTag = '0;

    logic fetchLoad; // New tag accepted into IF/ID
    logic idBubble;  // ID/EX gets an empty slot

    // Fetch only advances when PC and IF/ID move together
    assign fetchLoad = hz.pcWrite && hz.ifIdWrite;

    // Stall bubble or branch kill
    assign idBubble = !hz.controlMuxSel || hz.idFlush;

    // ------------------------------
    // IF/ID
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ifId <= EmptyTag;
        end else if (hz.ifFlush) begin
            ifId <= EmptyTag;  // Wrong-path fetch dropped
        end else if (fetchLoad) begin
            ifId <= fetchTag;
        end
        // Otherwise held, consumer waits in ID
    end

    // ------------------------------
    // ID/EX
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            idEx <= EmptyTag;
        end else if (idBubble) begin
            idEx <= EmptyTag;
        end else begin
            idEx <= ifId;
        end
    end

    // ------------------------------
    // EX/MEM and MEM/WB
    // ------------------------------

    // No stall reaches past EX, both stages always shift
    always_ff @(posedge clk) begin
        if (reset) begin
            exMem <= EmptyTag;
            memWb <= EmptyTag;
        end else begin
            exMem <= idEx;
            memWb <= exMem; // Retires next cycle via wb ports
        end
    end

endmodule

`default_nettype wire

//--- verilog/pipeline_config.svh
`ifndef PIPELINE_CONFIG_SVH
`define PIPELINE_CONFIG_SVH

// ------------------------------
// Register file
// ------------------------------

// Index width for 32 GPRs, r0 hardwired to zero
`define REG_ADDR_W 5

// ------------------------------
// Statistics
// ------------------------------

// Stall and flush counters, saturating
`define COUNT_W 16

`endif
